// File: bench/benchClock.sv
`timescale 1ns/10ps
`default_nettype none

module benchClock (
	output logic clock_o,
	output logic arstN_o
);

	localparam time HalfPeriod = 10ns; // 20 ns clock period

	initial begin
		clock_o = 1'b0;
		forever #HalfPeriod clock_o = ~clock_o;
	end

	// reset is held low for the first four rising edges
	initial begin
		arstN_o = 1'b0;
		repeat (4) @(posedge clock_o);
		arstN_o <= 1'b1;
	end

endmodule

`default_nettype wire

// File: bench/xoBench.sv
`timescale 1ns/10ps
`default_nettype none

`include "xoUnit_settings.svh"

module xoBench;

	typedef enum logic [2:0] {
		kindRegWrite,
		kindInstr,
		kindRegRead,
		kindStatusRead,
		kindBadAddr
	} testKind_e;

	typedef struct packed {
		logic [127:0] name;
		testKind_e kind;
		logic [`XO_ADDR_WIDTH-1:0] addr;
		logic [`XO_DATA_WIDTH-1:0] data;
		logic [`XO_DATA_WIDTH-1:0] expected;
	} testEntry_t;

	localparam int CyclesPerTest = 200;
	localparam logic [`XO_ADDR_WIDTH-1:0] UnmappedAddr = 12'h080;

	logic clock;
	logic arstN;
	logic [`XO_ADDR_WIDTH-1:0] awaddr;
	logic awvalid;
	logic [`XO_DATA_WIDTH-1:0] wdata;
	logic wvalid;
	logic bready;
	logic [`XO_ADDR_WIDTH-1:0] araddr;
	logic arvalid;
	logic rready;
	logic awready;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic arready;
	logic [`XO_DATA_WIDTH-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic watch;
	logic [127:0] testName;
	logic [`XO_DATA_WIDTH-1:0] expData;
	logic [1:0] expResp;
	logic testDone;
	logic allDone;
	logic tableReady;
	int errorCount;

	// reference state that the expected values are computed from
	logic [`XO_DATA_WIDTH-1:0] model [`XO_REG_COUNT];
	logic modelCa;
	logic modelOv;
	logic modelSo;
	logic [3:0] modelCr0;
	logic [7:0] modelRejects;
	logic [31:0] lfsr;
	testEntry_t tests [$];
	int xoCodes [11] = '{266, 40, 10, 8, 138, 136, 234, 232, 202, 200, 104};
	int chainCodes [6] = '{266, 138, 40, 10, 202, 104}; // add adde subf addc addze neg

	benchClock clockGen (.clock_o(clock), .arstN_o(arstN));

	xoTop dut (
		.clock_i(clock), .arstN_i(arstN),
		.awaddr_i(awaddr), .awvalid_i(awvalid), .wdata_i(wdata), .wvalid_i(wvalid),
		.bready_i(bready), .araddr_i(araddr), .arvalid_i(arvalid), .rready_i(rready),
		.awready_o(awready), .wready_o(wready), .bresp_o(bresp), .bvalid_o(bvalid),
		.arready_o(arready), .rdata_o(rdata), .rresp_o(rresp), .rvalid_o(rvalid)
	);

	xoChecker resultCheck (
		.clock_i(clock), .bvalid_i(bvalid), .bready_i(bready), .bresp_i(bresp),
		.rvalid_i(rvalid), .rready_i(rready), .rdata_i(rdata), .rresp_i(rresp),
		.watch_i(watch), .testName_i(testName), .expData_i(expData), .expResp_i(expResp),
		.testDone_i(testDone), .allDone_i(allDone), .errorCount_o(errorCount)
	);

	// right-shift Galois form with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	function automatic logic [`XO_ADDR_WIDTH-1:0] gprAddr(input int n);
		return `XO_ADDR_GPR_BASE + `XO_ADDR_WIDTH'(4 * n);
	endfunction

	// Power bits 0:5 opcode, 6:10 RT, 11:15 RA, 16:20 RB, 21 OE, 22:30 XO, 31 Rc
	function automatic logic [31:0] encodeXo(input logic [8:0] xo, input logic [4:0] rt,
			input logic [4:0] ra, input logic [4:0] rb, input logic oe, input logic rc);
		return {6'd31, rt, ra, rb, oe, xo, rc};
	endfunction

	function automatic logic [47:0] opName(input int xo);
		case (xo)
			266: return "add   ";
			40: return "subf  ";
			10: return "addc  ";
			8: return "subfc ";
			138: return "adde  ";
			136: return "subfe ";
			234: return "addme ";
			232: return "subfme";
			202: return "addze ";
			200: return "subfze";
			default: return "neg   ";
		endcase
	endfunction

	function automatic logic [31:0] expectedStatus();
		return {8'h00, modelRejects, 8'h00, 1'b0, modelSo, modelOv, modelCa, modelCr0};
	endfunction

	task automatic randomWord(output logic [31:0] word);
		for (int b = 0; b < 32; b++) begin
			lfsr = lfsrStep(lfsr);
			word = {word[30:0], lfsr[0]}; // one step per bit
		end
	endtask

	task automatic modelExec(input int xo, input int rt, input int ra, input int rb,
			input logic oe, input logic rc);
		logic [31:0] a;
		logic [31:0] b;
		logic cin;
		logic [32:0] total;
		logic [33:0] wide;
		logic ovf;
		a = model[ra];
		b = model[rb];
		cin = 1'b0;
		if (xo == 40 || xo == 8 || xo == 136 || xo == 232 || xo == 200 || xo == 104) begin
			a = ~a;
		end
		if (xo == 234 || xo == 232) begin
			b = 32'hFFFFFFFF;
		end else if (xo == 202 || xo == 200 || xo == 104) begin
			b = 32'h0;
		end
		if (xo == 40 || xo == 8 || xo == 104) begin
			cin = 1'b1;
		end else if (xo != 266 && xo != 10) begin
			cin = modelCa; // extended forms consume the carry
		end
		total = {1'b0, a} + {1'b0, b} + {32'h0, cin};
		wide = {{2{a[31]}}, a} + {{2{b[31]}}, b} + {33'h0, cin};
		ovf = wide[32] ^ wide[31]; // sum does not fit the signed 32-bit range
		model[rt] = total[31:0];
		if (xo != 266 && xo != 40 && xo != 104) begin
			modelCa = total[32];
		end
		if (oe) begin
			modelOv = ovf;
			modelSo = modelSo | ovf;
		end
		if (rc) begin
			modelCr0 = {$signed(total[31:0]) < 0, $signed(total[31:0]) > 0,
				total[31:0] == 0, modelSo};
		end
	endtask

	task automatic addTest(input logic [127:0] name, input testKind_e kind,
			input logic [`XO_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
			input logic [31:0] expected);
		tests.push_back({name, kind, addr, data, expected});
	endtask

	task automatic setRegister(input logic [127:0] name, input int n, input logic [31:0] value);
		model[n] = value;
		addTest(name, kindRegWrite, gprAddr(n), value, 32'h0);
	endtask

	task automatic checkRegister(input logic [127:0] name, input int n);
		addTest(name, kindRegRead, gprAddr(n), 32'h0, model[n]);
	endtask

	task automatic checkStatus(input logic [127:0] name);
		addTest(name, kindStatusRead, `XO_ADDR_STATUS, 32'h0, expectedStatus());
	endtask

	task automatic issueOp(input logic [127:0] name, input int xo, input int rt, input int ra,
			input int rb, input logic oe, input logic rc);
		modelExec(xo, rt, ra, rb, oe, rc);
		addTest(name, kindInstr, `XO_ADDR_INSTR, encodeXo(xo, rt, ra, rb, oe, rc), 32'h0);
	endtask

	task automatic issueBadWord(input logic [127:0] name, input logic [31:0] word);
		modelRejects = modelRejects + 8'h01;
		addTest(name, kindInstr, `XO_ADDR_INSTR, word, 32'h0);
	endtask

	task automatic buildTable();
		logic [31:0] word;
		logic [7:0] digit;
		for (int n = 1; n <= 4; n++) begin
			randomWord(word);
			digit = 8'h30 + 8'(n);
			setRegister({"load r", digit}, n, word);
		end
		setRegister("load max pos", 5, 32'h7FFFFFFF);
		setRegister("load one", 6, 32'h00000001);
		setRegister("load all ones", 7, 32'hFFFFFFFF);
		issueOp("addo. overflow", 266, 9, 5, 6, 1'b1, 1'b1);
		checkRegister("overflow rt", 9);
		checkStatus("overflow flags");
		issueOp("addco. carry", 10, 8, 7, 6, 1'b1, 1'b1); // SO must stay set
		checkRegister("carry rt", 8);
		checkStatus("carry flags");
		for (int i = 0; i < 11; i++) begin
			issueOp({opName(xoCodes[i]), " op"}, xoCodes[i], 10 + i, 1 + i % 4, 2 + i % 5,
				i[0], i[1]);
			checkRegister({opName(xoCodes[i]), " rt"}, 10 + i);
			checkStatus({opName(xoCodes[i]), " flags"});
		end
		randomWord(word);
		issueBadWord("bad primary", {6'd30, word[25:0]});
		issueBadWord("mullw rejected", encodeXo(235, 1, 2, 3, 1'b0, 1'b0));
		issueBadWord("divw rejected", encodeXo(491, 2, 3, 4, 1'b0, 1'b0));
		checkRegister("r1 unchanged", 1);
		checkRegister("r2 unchanged", 2);
		checkStatus("reject count");
		// each chained op reads the result of the one before it
		for (int k = 0; k < 6; k++) begin
			digit = 8'h30 + 8'(k);
			issueOp({"chain op ", digit}, chainCodes[k], 21 + k, (k == 0) ? 1 : 20 + k, 3,
				1'b0, k[0]);
		end
		for (int k = 0; k < 6; k++) begin
			digit = 8'h30 + 8'(k);
			checkRegister({"chain rt ", digit}, 21 + k);
		end
		checkStatus("chain flags");
		randomWord(word);
		addTest("bad address", kindBadAddr, UnmappedAddr, word, 32'h0);
	endtask

	// called and returning right after a rising edge
	task automatic axiWrite(input logic [`XO_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		@(posedge clock);
		while (!(awready && wready)) begin
			@(posedge clock);
		end
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		bready <= 1'b1;
		@(posedge clock);
		while (!bvalid) begin
			@(posedge clock);
		end
		bready <= 1'b0;
	endtask

	task automatic axiRead(input logic [`XO_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
		araddr <= addr;
		arvalid <= 1'b1;
		@(posedge clock);
		while (!arready) begin
			@(posedge clock);
		end
		arvalid <= 1'b0;
		rready <= 1'b1;
		@(posedge clock);
		while (!rvalid) begin
			@(posedge clock);
		end
		data = rdata;
		rready <= 1'b0;
	endtask

	task automatic waitIdle();
		logic [31:0] status;
		axiRead(`XO_ADDR_STATUS, status);
		while (status[7]) begin
			axiRead(`XO_ADDR_STATUS, status); // bit 7 is busy
		end
	endtask

	initial begin
		testEntry_t cur;
		logic [31:0] readData;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		watch = 1'b0;
		testName = '0;
		expData = '0;
		expResp = 2'b00;
		testDone = 1'b0;
		allDone = 1'b0;
		tableReady = 1'b0;
		lfsr = 32'd17600;
		for (int n = 0; n < `XO_REG_COUNT; n++) begin
			model[n] = '0;
		end
		modelCa = 1'b0;
		modelOv = 1'b0;
		modelSo = 1'b0;
		modelCr0 = 4'h0;
		modelRejects = 8'h00;
		buildTable();
		tableReady = 1'b1;
		wait (arstN === 1'b1);
		@(posedge clock);
		for (int i = 0; i < tests.size(); i++) begin
			cur = tests[i];
			if (cur.kind == kindRegRead || cur.kind == kindStatusRead
				|| cur.kind == kindBadAddr) begin
				waitIdle();
			end
			testName <= cur.name;
			expData <= cur.expected;
			expResp <= (cur.kind == kindBadAddr) ? 2'b10 : 2'b00; // SLVERR or OKAY
			watch <= 1'b1;
			if (cur.kind == kindRegWrite || cur.kind == kindInstr) begin
				axiWrite(cur.addr, cur.data);
			end else if (cur.kind == kindBadAddr) begin
				axiWrite(cur.addr, cur.data);
				axiRead(cur.addr, readData);
			end else begin
				axiRead(cur.addr, readData);
			end
			watch <= 1'b0;
			testDone <= 1'b1;
			@(posedge clock);
			testDone <= 1'b0;
		end
		allDone <= 1'b1;
		@(posedge clock);
		@(posedge clock);
		if (errorCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// the limit scales with the number of table entries
	initial begin
		wait (tableReady === 1'b1);
		repeat (tests.size() * CyclesPerTest) @(posedge clock);
		$display("Timeout: the tests did not finish within %0d clock cycles",
			tests.size() * CyclesPerTest);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/xoChecker.sv
`timescale 1ns/10ps
`default_nettype none

`include "xoUnit_settings.svh"

module xoChecker (
	input wire clock_i,
	input wire bvalid_i,
	input wire bready_i,
	input wire [1:0] bresp_i,
	input wire rvalid_i,
	input wire rready_i,
	input wire [`XO_DATA_WIDTH-1:0] rdata_i,
	input wire [1:0] rresp_i,
	input wire watch_i,
	input wire [127:0] testName_i,
	input wire [`XO_DATA_WIDTH-1:0] expData_i,
	input wire [1:0] expResp_i,
	input wire testDone_i,
	input wire allDone_i,
	output int errorCount_o
);

	int testCount;
	int failedTests;
	logic testFailed;
	logic summaryDone;

	initial begin
		errorCount_o = 0;
		testCount = 0;
		failedTests = 0;
		testFailed = 1'b0;
		summaryDone = 1'b0;
	end

	// handshakes are sampled at the edge where the DUT takes them
	always @(posedge clock_i) begin
		if (watch_i && bvalid_i && bready_i) begin
			if (bresp_i !== expResp_i) begin
				$display("Mismatch in %0s: expected BRESP %0d, actual %0d", testName_i,
					expResp_i, bresp_i);
				errorCount_o++;
				testFailed = 1'b1;
			end
		end
		if (watch_i && rvalid_i && rready_i) begin
			if (rresp_i !== expResp_i) begin
				$display("Mismatch in %0s: expected RRESP %0d, actual %0d", testName_i,
					expResp_i, rresp_i);
				errorCount_o++;
				testFailed = 1'b1;
			end
			if (rdata_i !== expData_i) begin
				$display("Mismatch in %0s: expected %h, actual %h", testName_i,
					expData_i, rdata_i);
				errorCount_o++;
				testFailed = 1'b1;
			end
		end
		if (testDone_i) begin
			testCount++;
			if (testFailed) begin
				failedTests++;
				$display("test %0s failed", testName_i);
			end else begin
				$display("test %0s passed", testName_i);
			end
			testFailed = 1'b0;
		end
		if (allDone_i && !summaryDone) begin
			summaryDone = 1'b1;
			$display("%0d tests run, %0d failing, %0d errors", testCount, failedTests,
				errorCount_o);
		end
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verilog
verilog/xoPkg.sv
verilog/xoAxiSlave.sv
verilog/xoDecoder.sv
verilog/xoOpFifo.sv
verilog/xoArithUnit.sv
verilog/xoTop.sv
bench/benchClock.sv
bench/xoChecker.sv
bench/xoBench.sv

// File: verilog/xoArithUnit.sv
`timescale 1ns/10ps
`default_nettype none

`include "xoUnit_settings.svh"

module xoArithUnit (
	input wire clock_i,
	input wire arstN_i,
	input wire xoPkg::xoMicroOp_t op_i,
	input wire opValid_i,
	output logic opReady_o,
	input wire xoPkg::regAccess_t req_i,
	input wire reqValid_i,
	output logic reqReady_o,
	output logic [`XO_DATA_WIDTH-1:0] rspData_o,
	output logic rspValid_o,
	output xoPkg::xoFlags_t flags_o
);

	localparam int Width = `XO_DATA_WIDTH;

	logic [Width-1:0] regFile [`XO_REG_COUNT];
	logic [Width-1:0] ra;
	logic [Width-1:0] rb;
	logic [Width-1:0] opA;
	logic [Width-1:0] opB;
	logic carryIn;
	logic [Width:0] sum;
	logic [Width-1:0] result;
	logic overflow;
	logic hostAccept;
	logic pop;
	xoPkg::xoFlags_t nextFlags;

	// one read in flight at a time, the slave waits for it anyway
	assign reqReady_o = !rspValid_o;
	assign hostAccept = reqValid_i && reqReady_o;
	assign opReady_o = !hostAccept; // host access steals the register file for this cycle
	assign pop = opValid_i && opReady_o;

	assign ra = regFile[op_i.ra];
	assign rb = regFile[op_i.rb];

	// every form is opA + opB + carryIn, subtracting forms invert RA
	always_comb begin
		opA = ra;
		opB = rb;
		carryIn = 1'b0;
		case (op_i.op)
			xoPkg::opAdd, xoPkg::opAddc: begin
				opA = ra;
				opB = rb;
				carryIn = 1'b0;
			end
			xoPkg::opSubf, xoPkg::opSubfc: begin
				opA = ~ra;
				opB = rb;
				carryIn = 1'b1;
			end
			xoPkg::opAdde: carryIn = flags_o.ca;
			xoPkg::opSubfe: begin
				opA = ~ra;
				carryIn = flags_o.ca;
			end
			xoPkg::opAddme: begin
				opB = '1;
				carryIn = flags_o.ca;
			end
			xoPkg::opSubfme: begin
				opA = ~ra;
				opB = '1;
				carryIn = flags_o.ca;
			end
			xoPkg::opAddze: begin
				opB = '0;
				carryIn = flags_o.ca;
			end
			xoPkg::opSubfze: begin
				opA = ~ra;
				opB = '0;
				carryIn = flags_o.ca;
			end
			xoPkg::opNeg: begin
				opA = ~ra;
				opB = '0;
				carryIn = 1'b1;
			end
			default: carryIn = 1'b0;
		endcase
	end

	assign sum = {1'b0, opA} + {1'b0, opB} + {{Width{1'b0}}, carryIn};
	assign result = sum[Width-1:0];
	// signed overflow when both operands agree in sign and the result does not
	assign overflow = (opA[Width-1] == opB[Width-1]) && (result[Width-1] != opA[Width-1]);

	always_comb begin
		nextFlags = flags_o;
		if ((op_i.op != xoPkg::opAdd) && (op_i.op != xoPkg::opSubf)
			&& (op_i.op != xoPkg::opNeg)) begin
			nextFlags.ca = sum[Width];
		end
		if (op_i.oe) begin
			nextFlags.ov = overflow;
			nextFlags.so = flags_o.so | overflow; // SO stays set until reset
		end
		if (op_i.rc) begin
			nextFlags.cr0 = {result[Width-1], !result[Width-1] && (result != '0),
				result == '0, nextFlags.so};
		end
	end

	always_ff @(posedge clock_i or negedge arstN_i) begin
		if (!arstN_i) begin
			for (int i = 0; i < `XO_REG_COUNT; i++) begin
				regFile[i] <= '0;
			end
			flags_o <= '0;
			rspValid_o <= 1'b0;
		end else begin
			rspValid_o <= hostAccept && !req_i.write;
			if (hostAccept && req_i.write) begin
				regFile[req_i.index] <= req_i.data;
			end else if (pop) begin
				regFile[op_i.rt] <= result;
				flags_o <= nextFlags;
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (hostAccept && !req_i.write) begin
			rspData_o <= regFile[req_i.index];
		end
	end

endmodule

`default_nettype wire

// File: verilog/xoAxiSlave.sv
`timescale 1ns/10ps
`default_nettype none

`include "xoUnit_settings.svh"

module xoAxiSlave (
	input wire clock_i,
	input wire arstN_i,
	input wire [`XO_ADDR_WIDTH-1:0] awaddr_i,
	input wire awvalid_i,
	input wire [`XO_DATA_WIDTH-1:0] wdata_i,
	input wire wvalid_i,
	input wire bready_i,
	input wire [`XO_ADDR_WIDTH-1:0] araddr_i,
	input wire arvalid_i,
	input wire rready_i,
	output logic awready_o,
	output logic wready_o,
	output logic [1:0] bresp_o,
	output logic bvalid_o,
	output logic arready_o,
	output logic [`XO_DATA_WIDTH-1:0] rdata_o,
	output logic [1:0] rresp_o,
	output logic rvalid_o,
	output logic [`XO_DATA_WIDTH-1:0] instr_o,
	output logic instrValid_o,
	input wire instrReady_i,
	output xoPkg::regAccess_t req_o,
	output logic reqValid_o,
	input wire reqReady_i,
	input wire [`XO_DATA_WIDTH-1:0] rspData_i,
	input wire rspValid_i,
	input wire xoPkg::xoFlags_t flags_i,
	input wire busy_i,
	input wire [7:0] rejectCount_i
);

	localparam logic [1:0] RespOkay = 2'b00;
	localparam logic [1:0] RespSlvErr = 2'b10;
	localparam int IndexWidth = $clog2(`XO_REG_COUNT);

	xoPkg::axiState_e state;
	logic [`XO_ADDR_WIDTH-1:0] arOffset;
	logic [`XO_ADDR_WIDTH-1:0] awOffset;
	logic rdIsGpr;
	logic rdIsStatus;
	logic wrIsGpr;
	logic wrIsInstr;
	logic readSel;
	logic writeSel;
	logic wrAccept;
	logic [`XO_DATA_WIDTH-1:0] statusWord;

	// offsets into the GPR window, only meaningful when the range check passes
	assign arOffset = araddr_i - `XO_ADDR_GPR_BASE;
	assign awOffset = awaddr_i - `XO_ADDR_GPR_BASE;

	assign rdIsGpr = (araddr_i >= `XO_ADDR_GPR_BASE) && (arOffset < `XO_REG_COUNT * 4)
		&& (arOffset[1:0] == 2'b00);
	assign wrIsGpr = (awaddr_i >= `XO_ADDR_GPR_BASE) && (awOffset < `XO_REG_COUNT * 4)
		&& (awOffset[1:0] == 2'b00);
	assign rdIsStatus = araddr_i == `XO_ADDR_STATUS;
	assign wrIsInstr = awaddr_i == `XO_ADDR_INSTR;

	assign statusWord = {8'h00, rejectCount_i, 8'h00, busy_i, flags_i.so, flags_i.ov,
		flags_i.ca, flags_i.cr0};

	// a read waiting in idle wins over a write arriving in the same cycle
	assign readSel = (state == xoPkg::stIdle) && arvalid_i;
	assign writeSel = (state == xoPkg::stIdle) && !arvalid_i && awvalid_i && wvalid_i;

	assign instr_o = wdata_i;

	always_comb begin
		instrValid_o = writeSel && wrIsInstr;
		reqValid_o = (readSel && rdIsGpr) || (writeSel && wrIsGpr);
		arready_o = readSel && (!rdIsGpr || reqReady_i); // status and bad reads never wait

		if (wrIsInstr) begin
			wrAccept = writeSel && instrReady_i;
		end else if (wrIsGpr) begin
			wrAccept = writeSel && reqReady_i;
		end else begin
			wrAccept = writeSel; // unmapped writes are answered at once
		end
		awready_o = wrAccept;
		wready_o = wrAccept;

		req_o.write = !readSel;
		req_o.index = readSel ? arOffset[2 +: IndexWidth] : awOffset[2 +: IndexWidth];
		req_o.data = wdata_i;
	end

	always_ff @(posedge clock_i or negedge arstN_i) begin
		if (!arstN_i) begin
			state <= xoPkg::stIdle;
			bvalid_o <= 1'b0;
			rvalid_o <= 1'b0;
			bresp_o <= RespOkay;
			rresp_o <= RespOkay;
			rdata_o <= '0;
		end else begin
			case (state)
				xoPkg::stIdle: begin
					if (arready_o) begin
						state <= xoPkg::stReadData;
						rresp_o <= (rdIsGpr || rdIsStatus) ? RespOkay : RespSlvErr;
						if (!rdIsGpr) begin
							// status and error reads have their data right now
							rvalid_o <= 1'b1;
							rdata_o <= rdIsStatus ? statusWord : '0;
						end
					end else if (wrAccept) begin
						state <= xoPkg::stWriteResp;
						bvalid_o <= 1'b1;
						bresp_o <= (wrIsInstr || wrIsGpr) ? RespOkay : RespSlvErr;
					end
				end
				xoPkg::stWriteResp: begin
					if (bready_i) begin
						bvalid_o <= 1'b0;
						state <= xoPkg::stIdle;
					end
				end
				xoPkg::stReadData: begin
					if (rvalid_o && rready_i) begin
						rvalid_o <= 1'b0;
						state <= xoPkg::stIdle;
					end else if (!rvalid_o && rspValid_i) begin
						rdata_o <= rspData_i; // GPR data from the arithmetic unit
						rvalid_o <= 1'b1;
					end
				end
				default: state <= xoPkg::stIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/xoDecoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "xoUnit_settings.svh"

module xoDecoder (
	input wire clock_i,
	input wire arstN_i,
	input wire [`XO_DATA_WIDTH-1:0] instr_i,
	input wire instrValid_i,
	output logic instrReady_o,
	output xoPkg::xoMicroOp_t op_o,
	output logic opValid_o,
	input wire opReady_i,
	output logic [7:0] rejectCount_o
);

	logic [5:0] primary;
	logic [8:0] extended;
	logic supported;
	logic accept;
	xoPkg::xoOp_e decodedOp;

	// Power numbering puts bit 0 at the MSB, so bits 0:5 are [31:26] here
	assign primary = instr_i[31:26];
	assign extended = instr_i[9:1]; // Power bits 22:30

	always_comb begin
		supported = primary == 6'd31;
		decodedOp = xoPkg::opAdd;
		case (extended)
			9'd266: decodedOp = xoPkg::opAdd;
			9'd40: decodedOp = xoPkg::opSubf;
			9'd10: decodedOp = xoPkg::opAddc;
			9'd8: decodedOp = xoPkg::opSubfc;
			9'd138: decodedOp = xoPkg::opAdde;
			9'd136: decodedOp = xoPkg::opSubfe;
			9'd234: decodedOp = xoPkg::opAddme;
			9'd232: decodedOp = xoPkg::opSubfme;
			9'd202: decodedOp = xoPkg::opAddze;
			9'd200: decodedOp = xoPkg::opSubfze;
			9'd104: decodedOp = xoPkg::opNeg;
			// multiply, divide and addg6s land here and get rejected
			default: supported = 1'b0;
		endcase
	end

	// the output register frees up when it is empty or drained this cycle
	assign instrReady_o = !opValid_o || opReady_i;
	assign accept = instrValid_i && instrReady_o;

	always_ff @(posedge clock_i or negedge arstN_i) begin
		if (!arstN_i) begin
			opValid_o <= 1'b0;
			rejectCount_o <= 8'h00;
		end else begin
			if (accept && supported) begin
				opValid_o <= 1'b1;
			end else if (opReady_i) begin
				opValid_o <= 1'b0;
			end

			if (accept && !supported && (rejectCount_o != 8'hFF)) begin
				rejectCount_o <= rejectCount_o + 8'h01; // saturates at 255
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (accept && supported) begin
			op_o.op <= decodedOp;
			op_o.rt <= instr_i[25:21]; // Power bits 6:10
			op_o.ra <= instr_i[20:16]; // Power bits 11:15
			op_o.rb <= instr_i[15:11]; // Power bits 16:20
			op_o.oe <= instr_i[10]; // Power bit 21
			op_o.rc <= instr_i[0]; // Power bit 31
		end
	end

endmodule

`default_nettype wire

// File: verilog/xoOpFifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "xoUnit_settings.svh"

module xoOpFifo (
	input wire clock_i,
	input wire arstN_i,
	input wire xoPkg::xoMicroOp_t in_i,
	input wire inValid_i,
	output logic inReady_o,
	output xoPkg::xoMicroOp_t out_o,
	output logic outValid_o,
	input wire outReady_i,
	output logic empty_o
);

	localparam int Depth = `XO_FIFO_DEPTH;
	localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CountWidth = $clog2(Depth + 1);

	xoPkg::xoMicroOp_t mem [Depth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CountWidth-1:0] count;
	logic full;
	logic push;
	logic pop;

	function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
		return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full = count == CountWidth'(Depth);
	assign empty_o = count == '0;
	assign outValid_o = !empty_o;
	assign inReady_o = !full || outReady_i; // a full buffer still takes a word while popping
	assign push = inValid_i && inReady_o;
	assign pop = outValid_o && outReady_i;
	assign out_o = mem[rdPtr];

	always_ff @(posedge clock_i or negedge arstN_i) begin
		if (!arstN_i) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (pop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock_i) begin
		if (push) begin
			mem[wrPtr] <= in_i;
		end
	end

endmodule

`default_nettype wire

// File: verilog/xoPkg.sv
`default_nettype none

`include "xoUnit_settings.svh"

package xoPkg;

	// the eleven XO add/subtract forms that the arithmetic unit executes
	typedef enum logic [3:0] {
		opAdd,
		opSubf,
		opAddc,
		opSubfc,
		opAdde,
		opSubfe,
		opAddme,
		opSubfme,
		opAddze,
		opSubfze,
		opNeg
	} xoOp_e;

	typedef enum logic [1:0] {
		stIdle,
		stWriteResp, // holding bvalid until bready
		stReadData // waiting for register data or holding rvalid
	} axiState_e;

	typedef struct packed {
		xoOp_e op;
		logic [$clog2(`XO_REG_COUNT)-1:0] rt;
		logic [$clog2(`XO_REG_COUNT)-1:0] ra;
		logic [$clog2(`XO_REG_COUNT)-1:0] rb;
		logic oe; // record signed overflow in OV and SO
		logic rc; // record result compare in CR0
	} xoMicroOp_t;

	// host access to one GPR, read when write is low
	typedef struct packed {
		logic write;
		logic [$clog2(`XO_REG_COUNT)-1:0] index;
		logic [`XO_DATA_WIDTH-1:0] data;
	} regAccess_t;

	typedef struct packed {
		logic ca;
		logic ov;
		logic so;
		logic [3:0] cr0; // LT, GT, EQ, SO from MSB down
	} xoFlags_t;

endpackage

`default_nettype wire

// File: verilog/xoTop.sv
`timescale 1ns/10ps
`default_nettype none

`include "xoUnit_settings.svh"

module xoTop (
	input wire clock_i,
	input wire arstN_i,
	input wire [`XO_ADDR_WIDTH-1:0] awaddr_i,
	input wire awvalid_i,
	input wire [`XO_DATA_WIDTH-1:0] wdata_i,
	input wire wvalid_i,
	input wire bready_i,
	input wire [`XO_ADDR_WIDTH-1:0] araddr_i,
	input wire arvalid_i,
	input wire rready_i,
	output logic awready_o,
	output logic wready_o,
	output logic [1:0] bresp_o,
	output logic bvalid_o,
	output logic arready_o,
	output logic [`XO_DATA_WIDTH-1:0] rdata_o,
	output logic [1:0] rresp_o,
	output logic rvalid_o
);

	logic [`XO_DATA_WIDTH-1:0] instr;
	logic instrValid;
	logic instrReady;
	xoPkg::regAccess_t regReq;
	logic regReqValid;
	logic regReqReady;
	logic [`XO_DATA_WIDTH-1:0] rspData;
	logic rspValid;
	xoPkg::xoFlags_t flags;
	logic busy;
	logic [7:0] rejectCount;
	xoPkg::xoMicroOp_t decOp;
	logic decOpValid;
	logic decOpReady;
	xoPkg::xoMicroOp_t fifoOp;
	logic fifoOpValid;
	logic fifoOpReady;
	logic fifoEmpty;

	// work is still in flight while the decoder holds an op or the FIFO has one queued
	assign busy = decOpValid | ~fifoEmpty;

	xoAxiSlave axiSlave (
		.clock_i(clock_i), .arstN_i(arstN_i),
		.awaddr_i(awaddr_i), .awvalid_i(awvalid_i), .wdata_i(wdata_i), .wvalid_i(wvalid_i),
		.bready_i(bready_i), .araddr_i(araddr_i), .arvalid_i(arvalid_i), .rready_i(rready_i),
		.awready_o(awready_o), .wready_o(wready_o), .bresp_o(bresp_o), .bvalid_o(bvalid_o),
		.arready_o(arready_o), .rdata_o(rdata_o), .rresp_o(rresp_o), .rvalid_o(rvalid_o),
		.instr_o(instr), .instrValid_o(instrValid), .instrReady_i(instrReady),
		.req_o(regReq), .reqValid_o(regReqValid), .reqReady_i(regReqReady),
		.rspData_i(rspData), .rspValid_i(rspValid),
		.flags_i(flags), .busy_i(busy), .rejectCount_i(rejectCount)
	);

	xoDecoder decoder (
		.clock_i(clock_i), .arstN_i(arstN_i),
		.instr_i(instr), .instrValid_i(instrValid), .instrReady_o(instrReady),
		.op_o(decOp), .opValid_o(decOpValid), .opReady_i(decOpReady),
		.rejectCount_o(rejectCount)
	);

	xoOpFifo opFifo (
		.clock_i(clock_i), .arstN_i(arstN_i),
		.in_i(decOp), .inValid_i(decOpValid), .inReady_o(decOpReady),
		.out_o(fifoOp), .outValid_o(fifoOpValid), .outReady_i(fifoOpReady),
		.empty_o(fifoEmpty)
	);

	xoArithUnit arithUnit (
		.clock_i(clock_i), .arstN_i(arstN_i),
		.op_i(fifoOp), .opValid_i(fifoOpValid), .opReady_o(fifoOpReady),
		.req_i(regReq), .reqValid_i(regReqValid), .reqReady_o(regReqReady),
		.rspData_o(rspData), .rspValid_o(rspValid), .flags_o(flags)
	);

endmodule

`default_nettype wire

// File: verilog/xoUnit_settings.svh
`ifndef XO_UNIT_SETTINGS_SVH
`define XO_UNIT_SETTINGS_SVH

// width of every general purpose register and of the AXI data bus
`define XO_DATA_WIDTH 32

`define XO_REG_COUNT 32 // GPR0 to GPR31

// decoded micro-ops that can wait between decoder and arithmetic unit
`define XO_FIFO_DEPTH 4

`define XO_ADDR_WIDTH 12

// AXI4-Lite address map, byte addresses
`define XO_ADDR_INSTR 12'h000 // instruction push, write only
`define XO_ADDR_STATUS 12'h004 // status word, read only
`define XO_ADDR_GPR_BASE 12'h100 // GPR n lives at base plus 4n

`endif
